// ==== sim.f ====
cu_pkg.sv
cex_if.sv
cycle_sequencer.sv
cond_eval.sv
cex_tracker.sv
exec_ctrl.sv
control_unit.sv
tb_control_unit_chk.sv
tb_control_unit.sv

// ==== Makefile ====
LOG = sim.log

all: run

run:
	verilator --binary --timing --assert -f sim.f --top-module tb_control_unit -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module tb_control_unit

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean

// ==== tb_control_unit.sv ====
`timescale 1ns/1ps

module tb_control_unit;

	localparam int n_alu      = 30;	// Register ALU, SRA and RRC
	localparam int n_br       = 40;
	localparam int n_cc       = 16;	// SETCC and CLRCC
	localparam int n_cex      = 10;
	localparam int cex_follow = 15;	// Enough to drain two full windows
	localparam int brk_hold   = 5;	// Cycles parked on the breakpoint
	localparam int n_instr    = 2 + n_alu + n_br + n_cc + n_cex * (1 + cex_follow) + brk_hold;
	localparam logic [cu_pkg::word_w-1:0] pc_run = 16'h0100;

	logic clock = 1'b0;	// Low before the first edge
	logic cpucycle_rst, rc, wb, id_en, psw_update, s_bus_ctrl, sxt_bus_ctrl, sxt_shift;
	logic breakpnt_set;
	logic [cu_pkg::word_w-1:0] pc, brkpnt, psw_in, psw_out;
	logic [cu_pkg::op_w-1:0] op;
	logic [2:0] dst, srccon, true_cnt, false_cnt, ctrl_reg_bus;
	logic [cu_pkg::cond_w-1:0] cond_field;
	logic [4:0] pswb, sxt_bit_num;
	logic [cu_pkg::bus_ctrl_w-1:0] data_bus_ctrl, addr_bus_ctrl;
	logic [1:0] psw_bus_ctrl;
	logic [cu_pkg::alu_op_w-1:0] alu_op;
	logic [cu_pkg::rnum_w-1:0] alu_rnum_dst, alu_rnum_src, dbus_rnum_dst, dbus_rnum_src;
	logic [cu_pkg::rnum_w-1:0] addr_rnum_src;
	logic [cu_pkg::cycle_w-1:0] cycle_out;
	logic [cu_pkg::cex_w-1:0] cex_state_out;

	logic [cu_pkg::cycle_w-1:0] m_cycle;	// Model state
	logic m_brk, m_act, m_res;
	logic [2:0] m_t, m_f;	// Model true and false windows
	logic [cu_pkg::bus_ctrl_w-1:0] e_data, e_addr;
	logic [cu_pkg::alu_op_w-1:0] e_alu;
	logic [cu_pkg::rnum_w-1:0] e_adst, e_asrc, e_ddst, e_dsrc, e_arsrc;
	logic [2:0] e_mem;	// Memory {ena, r/w, w/b}
	logic [1:0] e_psrc;
	logic [4:0] e_sxbit;
	logic e_id, e_upd, e_sbus, e_sxbus, e_sxsh;
	logic [cu_pkg::word_w-1:0] e_psw;
	string test_name;
	event checked;	// Compare done for this falling edge

	control_unit UUT (.*);

	always #50 clock = ~clock;

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_ctrl(input string name, input logic [cu_pkg::bus_ctrl_w-1:0] e, a);
		if (a !== e)
			stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, e, a));
	endtask

	task automatic check_rnum(input string name, input logic [cu_pkg::rnum_w-1:0] e, a);
		if (a !== e)
			stop_on_error($sformatf("MISMATCH %s expected %0d actual %0d", name, e, a));
	endtask

	task automatic check_alu(input string name, input logic [cu_pkg::alu_op_w-1:0] e, a);
		if (a !== e)
			stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, e, a));
	endtask

	task automatic check_psw(input string name, input logic [cu_pkg::word_w-1:0] e, a);
		if (a !== e)
			stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, e, a));
	endtask

	task automatic check_cycle(input string name, input logic [cu_pkg::cycle_w-1:0] e, a);
		if (a !== e)
			stop_on_error($sformatf("MISMATCH %s expected %0d actual %0d", name, e, a));
	endtask

	task automatic check_flag(input string name, input logic e, a);
		if (a !== e)
			stop_on_error($sformatf("MISMATCH %s expected %b actual %b", name, e, a));
	endtask

	task automatic check_mem(input string name, input logic [2:0] e, a);
		if (a !== e)
			stop_on_error($sformatf("MISMATCH %s expected %b actual %b", name, e, a));
	endtask

	task automatic check_psw_src(input string name, input logic [1:0] e, a);
		if (a !== e)
			stop_on_error($sformatf("MISMATCH %s expected %0d actual %0d", name, e, a));
	endtask

	task automatic check_bit_pos(input string name, input logic [4:0] e, a);
		if (a !== e)
			stop_on_error($sformatf("MISMATCH %s expected %0d actual %0d", name, e, a));
	endtask

	task automatic check_cex(input string name, input logic [cu_pkg::cex_w-1:0] e, a);
		if (a !== e)
			stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, e, a));
	endtask

	function automatic logic cond_true(input logic [cu_pkg::cond_w-1:0] code,
		input logic [cu_pkg::word_w-1:0] psw);
		logic c;
		logic z;
		logic n;
		logic v;
		c = psw[cu_pkg::psw_c];
		z = psw[cu_pkg::psw_z];
		n = psw[cu_pkg::psw_n];
		v = psw[cu_pkg::psw_v];
		case (code)
			cu_pkg::cond_eq, cu_pkg::cond_ne: return z ^ code[0];	// Odd codes invert
			cu_pkg::cond_cs, cu_pkg::cond_cc: return c ^ code[0];
			cu_pkg::cond_mi, cu_pkg::cond_pl: return n ^ code[0];
			cu_pkg::cond_vs, cu_pkg::cond_vc: return v ^ code[0];
			cu_pkg::cond_hi: return c && !z;
			cu_pkg::cond_ls: return !c || z;
			cu_pkg::cond_ge: return n == v;
			cu_pkg::cond_lt: return n != v;
			cu_pkg::cond_gt: return !z && (n == v);
			cu_pkg::cond_le: return z || (n != v);
			cu_pkg::cond_al: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Branch opcode to the condition it tests
	function automatic logic [cu_pkg::cond_w-1:0] branch_code(
		input logic [cu_pkg::op_w-1:0] bop);
		case (bop)
			7'd1: return cu_pkg::cond_eq;
			7'd2: return cu_pkg::cond_ne;
			7'd3: return cu_pkg::cond_cs;
			7'd4: return cu_pkg::cond_cc;
			7'd5: return cu_pkg::cond_mi;
			7'd6: return cu_pkg::cond_ge;
			7'd7: return cu_pkg::cond_lt;
			default: return cu_pkg::cond_gt;	// Opcode 8
		endcase
	endfunction

	// Execute unless the open window rules this instruction out
	function automatic logic model_skip();
		return m_act && !((m_res && m_t != 3'd0) || (!m_res && m_t == 3'd0 && m_f != 3'd0));
	endfunction

	function automatic void ref_ctrl(input logic [cu_pkg::cycle_w-1:0] cyc, input logic halt,
		input logic skip, output logic [cu_pkg::bus_ctrl_w-1:0] d,
		output logic [cu_pkg::bus_ctrl_w-1:0] a,
		output logic [cu_pkg::alu_op_w-1:0] alu, output logic [cu_pkg::rnum_w-1:0] adst,
		output logic [cu_pkg::rnum_w-1:0] asrc, output logic [cu_pkg::rnum_w-1:0] ddst,
		output logic [cu_pkg::rnum_w-1:0] dsrc, output logic [cu_pkg::rnum_w-1:0] arsrc,
		output logic [2:0] mem, output logic [1:0] psrc, output logic sbus,
		output logic sxbus, output logic sxsh, output logic [4:0] sxbit,
		output logic id, output logic upd, output logic [cu_pkg::word_w-1:0] psw);
		d = cu_pkg::bus_ctrl_idle;
		a = cu_pkg::bus_ctrl_idle;
		alu = '0;
		adst = '0;
		asrc = '0;
		ddst = '0;
		dsrc = '0;
		arsrc = '0;
		mem = 3'b000;
		psrc = cu_pkg::psw_src_none;
		sbus = 1'b0;
		sxbus = 1'b0;
		sxsh = 1'b0;
		sxbit = 5'd0;
		id = 1'b0;
		upd = 1'b0;
		psw = psw_in;
		if (!halt && (cyc == cu_pkg::cyc_fetch || cyc == cu_pkg::cyc_pc_wb))
		begin
			if (cyc == cu_pkg::cyc_fetch)
			begin
				a = {1'b0, cu_pkg::bus_reg, cu_pkg::bus_mdr};	// PC to MAR, memory read
				arsrc = cu_pkg::reg_pc;
				mem = cu_pkg::ctrl_mem_read;
			end
			else
				d = {1'b0, cu_pkg::bus_alu, cu_pkg::bus_reg};
			adst = cu_pkg::reg_pc;	// PC + 2
			asrc = cu_pkg::reg_const2;
			ddst = cu_pkg::reg_pc;
		end
		else if (!halt && cyc == cu_pkg::cyc_ir_load)
			d = {1'b0, cu_pkg::bus_mdr, cu_pkg::bus_ir};
		else if (!halt && cyc == cu_pkg::cyc_decode)
			id = !skip;
		else if (!halt && cyc == cu_pkg::cyc_exec)
		begin
			if (op >= cu_pkg::op_beq && op <= cu_pkg::op_bra && cond_true(branch_code(op), psw_in))
			begin
				d = {1'b0, cu_pkg::bus_alu, cu_pkg::bus_reg};	// PC + offset
				adst = cu_pkg::reg_pc;
				ddst = cu_pkg::reg_pc;
				sbus = 1'b1;
				sxbus = 1'b1;
				sxsh = 1'b1;
				sxbit = 5'd10;
			end
			else if ((op >= cu_pkg::op_add && op <= cu_pkg::op_bis) || op == cu_pkg::op_sra
				|| op == cu_pkg::op_rrc)
			begin
				alu = 6'((op - ((op >= cu_pkg::op_sra) ? 7'd11 : cu_pkg::op_add)) * 7'd2 + 7'(wb));
				upd = 1'b1;
				psrc = cu_pkg::psw_src_alu;
				adst = {2'b00, dst};
				asrc = {2'b00, srccon} + (rc ? 5'd8 : 5'd0);	// Constant bank
				ddst = {2'b00, dst};
				d = {wb, cu_pkg::bus_alu, cu_pkg::bus_reg};
			end
			else if (op == cu_pkg::op_mov)
			begin
				ddst = {2'b00, dst};
				dsrc = {2'b00, srccon};
				d = {wb, cu_pkg::bus_reg, cu_pkg::bus_reg};
			end
			else if (op == cu_pkg::op_setcc)
				psw = psw_in | {11'd0, pswb};
			else if (op == cu_pkg::op_clrcc)
				psw = psw_in & ~{11'd0, pswb};
		end
	endfunction

	always @(posedge clock)	// Reference cycle and CEX state
	begin
		if (cpucycle_rst)
		begin
			m_cycle <= cu_pkg::cyc_fetch;
			{m_brk, m_act, m_res, m_t, m_f} <= '0;
		end
		else
		begin
			if (m_brk)
				m_brk <= (pc == brkpnt);
			else if (m_cycle == cu_pkg::cyc_fetch && pc == brkpnt)
				m_brk <= 1'b1;
			else if (m_cycle == cu_pkg::cyc_exec || (m_cycle == cu_pkg::cyc_decode && model_skip()))
				m_cycle <= cu_pkg::cyc_fetch;
			else
				m_cycle <= m_cycle + 4'd1;
			if (!m_brk && m_cycle == cu_pkg::cyc_exec && op == cu_pkg::op_cex)
			begin
				{m_act, m_t, m_f} <= {1'b1, true_cnt, false_cnt};
				m_res <= cond_true(cond_field, psw_in);
			end
			else if (!m_brk && m_cycle == cu_pkg::cyc_decode && m_act)
			begin
				m_t <= (m_t != 3'd0) ? m_t - 3'd1 : m_t;	// True window drains first
				m_f <= (m_t == 3'd0 && m_f != 3'd0) ? m_f - 3'd1 : m_f;
				m_act <= ({1'b0, m_t} + {1'b0, m_f}) > 4'd1;
			end
		end
	end

	always
	begin
		@(negedge clock);
		if (!cpucycle_rst)
		begin
			ref_ctrl(m_cycle, m_brk, model_skip(), e_data, e_addr, e_alu, e_adst, e_asrc, e_ddst,
				e_dsrc, e_arsrc, e_mem, e_psrc, e_sbus, e_sxbus, e_sxsh, e_sxbit,
				e_id, e_upd, e_psw);
			check_cycle({test_name, " cycle_out"}, m_cycle, cycle_out);
			check_flag({test_name, " breakpnt_set"}, m_brk, breakpnt_set);
			check_cex({test_name, " cex_state_out"}, {m_act, m_res, m_t, m_f}, cex_state_out);
			check_ctrl({test_name, " data_bus_ctrl"}, e_data, data_bus_ctrl);
			check_ctrl({test_name, " addr_bus_ctrl"}, e_addr, addr_bus_ctrl);
			check_mem({test_name, " ctrl_reg_bus"}, e_mem, ctrl_reg_bus);
			check_alu({test_name, " alu_op"}, e_alu, alu_op);
			check_rnum({test_name, " alu_rnum_dst"}, e_adst, alu_rnum_dst);
			check_rnum({test_name, " alu_rnum_src"}, e_asrc, alu_rnum_src);
			check_rnum({test_name, " dbus_rnum_dst"}, e_ddst, dbus_rnum_dst);
			check_rnum({test_name, " dbus_rnum_src"}, e_dsrc, dbus_rnum_src);
			check_rnum({test_name, " addr_rnum_src"}, e_arsrc, addr_rnum_src);
			check_flag({test_name, " s_bus_ctrl"}, e_sbus, s_bus_ctrl);
			check_flag({test_name, " sxt_bus_ctrl"}, e_sxbus, sxt_bus_ctrl);
			check_flag({test_name, " sxt_shift"}, e_sxsh, sxt_shift);
			check_bit_pos({test_name, " sxt_bit_num"}, e_sxbit, sxt_bit_num);
			check_flag({test_name, " id_en"}, e_id, id_en);
			check_flag({test_name, " psw_update"}, e_upd, psw_update);
			check_psw_src({test_name, " psw_bus_ctrl"}, e_psrc, psw_bus_ctrl);
			check_psw({test_name, " psw_out"}, e_psw, psw_out);
		end
		-> checked;	// Stimulus may now drive
	end

	function automatic logic [cu_pkg::op_w-1:0] pick_alu();
		int r;
		r = int'($urandom_range(0, 13));
		return (r < 12) ? cu_pkg::op_add + 7'(r) : cu_pkg::op_sra + 7'(r - 12);
	endfunction

	// Start at a fetch, drive random fields, count clocks until the next fetch
	task automatic run_instr(input string name, input logic [cu_pkg::op_w-1:0] i_op);
		logic [cu_pkg::cycle_w-1:0] len;
		logic exp_skip;
		while (cycle_out != cu_pkg::cyc_fetch || breakpnt_set)
			@(checked);
		test_name = name;
		op = i_op;
		{dst, srccon, rc, wb, true_cnt, false_cnt, pswb} = 19'($urandom);
		cond_field = 4'($urandom_range(0, 14));
		psw_in = 16'($urandom);
		exp_skip = model_skip();
		len = 4'd1;
		@(checked);
		while (cycle_out != cu_pkg::cyc_fetch)
		begin
			len = len + 4'd1;
			@(checked);
		end
		check_cycle({name, " length"}, exp_skip ? 4'd4 : 4'd5, len);
	endtask

	task automatic run_breakpoint();
		while (cycle_out != cu_pkg::cyc_fetch || breakpnt_set)
			@(checked);
		test_name = "breakpoint";
		pc = brkpnt;	// Hit at this fetch
		@(checked);
		check_flag("breakpoint set", 1'b1, breakpnt_set);
		repeat (brk_hold)
		begin
			@(checked);
			check_cycle("breakpoint hold", cu_pkg::cyc_fetch, cycle_out);
		end
		pc = pc_run;	// Release on the next edge
	endtask

	initial
	begin
		#((n_instr * 6 + 10) * 100);
		stop_on_error("Timeout: the run did not finish in the expected time");
	end

	initial
	begin
		void'($urandom(32'hc9cc3674));
		cpucycle_rst = 1'b1;
		pc = pc_run;
		brkpnt = 16'h0F00;
		{op, dst, srccon, rc, wb, cond_field, true_cnt, false_cnt, pswb, psw_in} = '0;
		test_name = "reset";
		repeat (10) @(checked);
		cpucycle_rst = 1'b0;
		run_instr("reset_fetch", cu_pkg::op_mov);
		repeat (n_alu) run_instr("alu_op", pick_alu());
		repeat (n_br) run_instr("branch", 7'($urandom_range(1, 8)));
		repeat (n_cc)
			run_instr("setcc_clrcc", $urandom_range(0, 1) == 1 ? cu_pkg::op_setcc : cu_pkg::op_clrcc);
		repeat (n_cex)
		begin
			run_instr("cex", cu_pkg::op_cex);
			repeat (cex_follow) run_instr("cex_window", pick_alu());
		end
		run_breakpoint();
		run_instr("after_breakpoint", pick_alu());
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== tb_control_unit_chk.sv ====
`timescale 1ns/1ps

module tb_control_unit_chk
(
	input logic                          clock,
	input logic                          cpucycle_rst,
	input logic [cu_pkg::cycle_w-1:0]    cycle_out,
	input logic                          id_en,
	input logic                          breakpnt_set,
	input logic [cu_pkg::bus_ctrl_w-1:0] data_bus_ctrl
);

	cycle_range: assert property (@(posedge clock) disable iff (cpucycle_rst)
		cycle_out >= cu_pkg::cyc_fetch && cycle_out <= cu_pkg::cyc_exec)
		else $error("cycle counter left the range 1 to 5");

	decode_only: assert property (@(posedge clock) disable iff (cpucycle_rst)
		id_en |-> cycle_out == cu_pkg::cyc_decode)
		else $error("decode strobe outside the decode cycle");

	brk_at_fetch: assert property (@(posedge clock) disable iff (cpucycle_rst)
		breakpnt_set |-> cycle_out == cu_pkg::cyc_fetch)
		else $error("breakpoint hold away from fetch");

	fetch_bus_idle: assert property (@(posedge clock) disable iff (cpucycle_rst)
		cycle_out == cu_pkg::cyc_fetch |-> data_bus_ctrl == cu_pkg::bus_ctrl_idle)
		else $error("data bus driven during fetch");

endmodule

bind control_unit tb_control_unit_chk u_chk
(
	.clock         (clock),
	.cpucycle_rst  (cpucycle_rst),
	.cycle_out     (cycle_out),
	.id_en         (id_en),
	.breakpnt_set  (breakpnt_set),
	.data_bus_ctrl (data_bus_ctrl)
);

// ==== control_unit.sv ====
`timescale 1ns/1ps

module control_unit
(
	input  logic                          clock,
	input  logic                          cpucycle_rst,
	input  logic [cu_pkg::word_w-1:0]     pc,
	input  logic [cu_pkg::word_w-1:0]     brkpnt,
	input  logic [cu_pkg::op_w-1:0]       op,
	input  logic [2:0]                    dst,
	input  logic [2:0]                    srccon,
	input  logic                          rc,
	input  logic                          wb,
	input  logic [cu_pkg::cond_w-1:0]     cond_field,
	input  logic [2:0]                    true_cnt,
	input  logic [2:0]                    false_cnt,
	input  logic [4:0]                    pswb,
	input  logic [cu_pkg::word_w-1:0]     psw_in,
	output logic                          id_en,
	output logic [2:0]                    ctrl_reg_bus,
	output logic [cu_pkg::bus_ctrl_w-1:0] data_bus_ctrl,
	output logic [cu_pkg::bus_ctrl_w-1:0] addr_bus_ctrl,
	output logic [1:0]                    psw_bus_ctrl,
	output logic                          psw_update,
	output logic [cu_pkg::alu_op_w-1:0]   alu_op,
	output logic [cu_pkg::rnum_w-1:0]     alu_rnum_dst,
	output logic [cu_pkg::rnum_w-1:0]     alu_rnum_src,
	output logic [cu_pkg::rnum_w-1:0]     dbus_rnum_dst,
	output logic [cu_pkg::rnum_w-1:0]     dbus_rnum_src,
	output logic [cu_pkg::rnum_w-1:0]     addr_rnum_src,
	output logic                          s_bus_ctrl,
	output logic                          sxt_bus_ctrl,
	output logic                          sxt_shift,
	output logic [4:0]                    sxt_bit_num,
	output logic [cu_pkg::word_w-1:0]     psw_out,
	output logic [cu_pkg::cycle_w-1:0]    cycle_out,
	output logic                          breakpnt_set,
	output logic [cu_pkg::cex_w-1:0]      cex_state_out
);

	logic instr_done;	// Current instruction ends this cycle

	cex_if cex_bus();

	cycle_sequencer u_cycle_sequencer
	(
		.clock        (clock),
		.cpucycle_rst (cpucycle_rst),
		.pc           (pc),
		.brkpnt       (brkpnt),
		.instr_done   (instr_done),
		.cycle        (cycle_out),
		.halted       (breakpnt_set)
	);

	cex_tracker u_cex_tracker
	(
		.clock        (clock),
		.cpucycle_rst (cpucycle_rst),
		.cex          (cex_bus.tracker)
	);

	exec_ctrl u_exec_ctrl
	(
		.cycle (cycle_out), .halted (breakpnt_set),
		.op (op), .dst (dst), .srccon (srccon), .rc (rc), .wb (wb),
		.cond_field (cond_field), .true_cnt (true_cnt), .false_cnt (false_cnt),
		.pswb (pswb), .psw_in (psw_in), .instr_done (instr_done), .id_en (id_en),
		.ctrl_reg_bus (ctrl_reg_bus), .data_bus_ctrl (data_bus_ctrl),
		.addr_bus_ctrl (addr_bus_ctrl), .psw_bus_ctrl (psw_bus_ctrl),
		.psw_update (psw_update), .alu_op (alu_op),
		.alu_rnum_dst (alu_rnum_dst), .alu_rnum_src (alu_rnum_src),
		.dbus_rnum_dst (dbus_rnum_dst), .dbus_rnum_src (dbus_rnum_src),
		.addr_rnum_src (addr_rnum_src), .s_bus_ctrl (s_bus_ctrl),
		.sxt_bus_ctrl (sxt_bus_ctrl), .sxt_shift (sxt_shift),
		.sxt_bit_num (sxt_bit_num), .psw_out (psw_out),
		.cex (cex_bus.exec)
	);

	assign cex_state_out = cex_bus.cex_state;	// Visible for debug

endmodule

// ==== exec_ctrl.sv ====
`timescale 1ns/1ps

module exec_ctrl
(
	input  logic [cu_pkg::cycle_w-1:0]    cycle,
	input  logic                          halted,
	input  logic [cu_pkg::op_w-1:0]       op,
	input  logic [2:0]                    dst,
	input  logic [2:0]                    srccon,
	input  logic                          rc,		// Source is a constant register
	input  logic                          wb,		// Byte operation
	input  logic [cu_pkg::cond_w-1:0]     cond_field,
	input  logic [2:0]                    true_cnt,
	input  logic [2:0]                    false_cnt,
	input  logic [4:0]                    pswb,
	input  logic [cu_pkg::word_w-1:0]     psw_in,
	output logic                          instr_done,
	output logic                          id_en,
	output logic [2:0]                    ctrl_reg_bus,	// Memory {ena, r/w, w/b}
	output logic [cu_pkg::bus_ctrl_w-1:0] data_bus_ctrl,
	output logic [cu_pkg::bus_ctrl_w-1:0] addr_bus_ctrl,
	output logic [1:0]                    psw_bus_ctrl,
	output logic                          psw_update,
	output logic [cu_pkg::alu_op_w-1:0]   alu_op,
	output logic [cu_pkg::rnum_w-1:0]     alu_rnum_dst,
	output logic [cu_pkg::rnum_w-1:0]     alu_rnum_src,
	output logic [cu_pkg::rnum_w-1:0]     dbus_rnum_dst,
	output logic [cu_pkg::rnum_w-1:0]     dbus_rnum_src,
	output logic [cu_pkg::rnum_w-1:0]     addr_rnum_src,
	output logic                          s_bus_ctrl,	// ALU S input from sign extender
	output logic                          sxt_bus_ctrl,	// Extender takes the offset field
	output logic                          sxt_shift,	// Offset shifted left by one
	output logic [4:0]                    sxt_bit_num,
	output logic [cu_pkg::word_w-1:0]     psw_out,
	cex_if.exec                           cex
);

	logic                        is_branch;
	logic [cu_pkg::cond_w-1:0]   branch_cond;
	logic [cu_pkg::cond_w-1:0]   cond_sel;
	logic                        cond_taken;
	logic [cu_pkg::alu_op_w-2:0] op_off;	// ALU operation without the w/b bit
	logic [cu_pkg::rnum_w-1:0]   dst_rnum;
	logic [cu_pkg::rnum_w-1:0]   src_rnum;

	assign is_branch = (op >= cu_pkg::op_beq) && (op <= cu_pkg::op_bra);

	// BEQ..BMI map onto EQ..MI, the last three onto GE..GT
	assign branch_cond = (op <= 7'd5) ? op[cu_pkg::cond_w-1:0] - 4'd1
		: op[cu_pkg::cond_w-1:0] + 4'd4;
	assign cond_sel = is_branch ? branch_cond : cond_field;

	cond_eval u_cond_eval
	(
		.cond  (cond_sel),
		.flags (psw_in),
		.taken (cond_taken)
	);

	// SRA and RRC follow the ADD group in the ALU encoding
	assign op_off = (op >= cu_pkg::op_sra) ? (cu_pkg::alu_op_w-1)'(op - 7'd11)
		: (cu_pkg::alu_op_w-1)'(op - cu_pkg::op_add);

	assign dst_rnum = {2'b00, dst};
	assign src_rnum = {1'b0, rc, srccon};	// Constants sit eight above R0

	assign cex.cex_cond_true = cond_taken;
	assign cex.cex_true_cnt  = true_cnt;
	assign cex.cex_false_cnt = false_cnt;
	assign cex.decode_step   = (cycle == cu_pkg::cyc_decode) && ~halted;

	always_comb
	begin
		instr_done    = 1'b0;
		id_en         = 1'b0;
		ctrl_reg_bus  = 3'b000;
		data_bus_ctrl = cu_pkg::bus_ctrl_idle;
		addr_bus_ctrl = cu_pkg::bus_ctrl_idle;
		psw_bus_ctrl  = cu_pkg::psw_src_none;
		psw_update    = 1'b0;
		alu_op        = '0;
		alu_rnum_dst  = '0;
		alu_rnum_src  = '0;
		dbus_rnum_dst = '0;
		dbus_rnum_src = '0;
		addr_rnum_src = '0;
		s_bus_ctrl    = 1'b0;
		sxt_bus_ctrl  = 1'b0;
		sxt_shift     = 1'b0;
		sxt_bit_num   = 5'd0;
		psw_out       = psw_in;
		cex.cex_load  = 1'b0;

		if (!halted)
		begin
			case (cycle)
				cu_pkg::cyc_fetch:
				begin
					addr_bus_ctrl = {1'b0, cu_pkg::bus_reg, cu_pkg::bus_mdr};	// PC to MAR
					addr_rnum_src = cu_pkg::reg_pc;
					ctrl_reg_bus  = cu_pkg::ctrl_mem_read;
					alu_rnum_dst  = cu_pkg::reg_pc;		// PC + 2
					alu_rnum_src  = cu_pkg::reg_const2;
					dbus_rnum_dst = cu_pkg::reg_pc;
				end
				cu_pkg::cyc_pc_wb:
				begin
					alu_rnum_dst  = cu_pkg::reg_pc;		// Hold the add
					alu_rnum_src  = cu_pkg::reg_const2;
					dbus_rnum_dst = cu_pkg::reg_pc;
					data_bus_ctrl = {1'b0, cu_pkg::bus_alu, cu_pkg::bus_reg};
				end
				cu_pkg::cyc_ir_load:
					data_bus_ctrl = {1'b0, cu_pkg::bus_mdr, cu_pkg::bus_ir};
				cu_pkg::cyc_decode:
				begin
					id_en      = ~cex.cex_skip;
					instr_done = cex.cex_skip;		// Ruled out by CEX, no execute
				end
				cu_pkg::cyc_exec:
				begin
					instr_done = 1'b1;
					case (op) inside
						[cu_pkg::op_beq:cu_pkg::op_bra]:
						begin
							if (cond_taken)
							begin
								sxt_bit_num   = 5'd10;		// 11-bit offset field
								sxt_shift     = 1'b1;		// Word offset
								sxt_bus_ctrl  = 1'b1;
								s_bus_ctrl    = 1'b1;
								alu_rnum_dst  = cu_pkg::reg_pc;	// PC + offset
								dbus_rnum_dst = cu_pkg::reg_pc;
								data_bus_ctrl = {1'b0, cu_pkg::bus_alu, cu_pkg::bus_reg};
							end
						end
						[cu_pkg::op_add:cu_pkg::op_bis], cu_pkg::op_sra, cu_pkg::op_rrc:
						begin
							alu_op        = {op_off, wb};
							psw_update    = 1'b1;
							psw_bus_ctrl  = cu_pkg::psw_src_alu;
							alu_rnum_dst  = dst_rnum;
							alu_rnum_src  = src_rnum;
							dbus_rnum_dst = dst_rnum;
							data_bus_ctrl = {wb, cu_pkg::bus_alu, cu_pkg::bus_reg};
						end
						cu_pkg::op_mov:
						begin
							dbus_rnum_dst = dst_rnum;
							dbus_rnum_src = {2'b00, srccon};
							data_bus_ctrl = {wb, cu_pkg::bus_reg, cu_pkg::bus_reg};
						end
						cu_pkg::op_setcc:
							psw_out = {psw_in[cu_pkg::word_w-1:5], psw_in[4:0] | pswb};
						cu_pkg::op_clrcc:
							psw_out = {psw_in[cu_pkg::word_w-1:5], psw_in[4:0] & ~pswb};
						cu_pkg::op_cex:
							cex.cex_load = 1'b1;	// Window opens on this edge
						default:
							instr_done = 1'b1;	// Unsupported op does nothing
					endcase
				end
				default:
					instr_done = 1'b0;
			endcase
		end
	end

endmodule

// ==== cex_tracker.sv ====
`timescale 1ns/1ps

module cex_tracker
(
	input  logic clock,
	input  logic cpucycle_rst,
	cex_if.tracker cex
);

	logic       active;		// CEX window open
	logic       result;		// Condition was true at CEX
	logic [2:0] true_cnt;	// Remaining true-window instructions
	logic [2:0] false_cnt;	// Remaining false-window instructions
	logic [2:0] true_nx;
	logic [2:0] false_nx;
	logic       run;		// Current instruction may execute

	// True window first, false window after it
	assign run = ~active
		| (result & (true_cnt != 3'd0))
		| (~result & (true_cnt == 3'd0) & (false_cnt != 3'd0));

	assign cex.cex_skip = ~run;

	always_comb
	begin
		true_nx  = true_cnt;
		false_nx = false_cnt;
		if (true_cnt != 3'd0)
			true_nx = true_cnt - 3'd1;
		else if (false_cnt != 3'd0)
			false_nx = false_cnt - 3'd1;
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			active    <= 1'b0;
			result    <= 1'b0;
			true_cnt  <= 3'd0;
			false_cnt <= 3'd0;
		end
		else if (cex.cex_load)
		begin
			active    <= 1'b1;
			result    <= cex.cex_cond_true;
			true_cnt  <= cex.cex_true_cnt;
			false_cnt <= cex.cex_false_cnt;
		end
		else if (cex.decode_step && active)
		begin
			true_cnt  <= true_nx;
			false_cnt <= false_nx;
			active    <= (true_nx != 3'd0) || (false_nx != 3'd0);	// Close when both drained
		end
	end

	assign cex.cex_state = {active, result, true_cnt, false_cnt};

endmodule

// ==== cond_eval.sv ====
`timescale 1ns/1ps

module cond_eval
(
	input  logic [cu_pkg::cond_w-1:0] cond,
	input  logic [cu_pkg::word_w-1:0] flags,	// PSW
	output logic                      taken
);

	logic c_f;
	logic z_f;
	logic n_f;
	logic v_f;

	assign c_f = flags[cu_pkg::psw_c];
	assign z_f = flags[cu_pkg::psw_z];
	assign n_f = flags[cu_pkg::psw_n];
	assign v_f = flags[cu_pkg::psw_v];

	always_comb
	begin
		case (cond)
			cu_pkg::cond_eq: taken = z_f;
			cu_pkg::cond_ne: taken = ~z_f;
			cu_pkg::cond_cs: taken = c_f;
			cu_pkg::cond_cc: taken = ~c_f;
			cu_pkg::cond_mi: taken = n_f;
			cu_pkg::cond_pl: taken = ~n_f;
			cu_pkg::cond_vs: taken = v_f;
			cu_pkg::cond_vc: taken = ~v_f;
			cu_pkg::cond_hi: taken = c_f & ~z_f;
			cu_pkg::cond_ls: taken = ~c_f | z_f;
			cu_pkg::cond_ge: taken = (n_f == v_f);
			cu_pkg::cond_lt: taken = (n_f != v_f);
			cu_pkg::cond_gt: taken = ~z_f & (n_f == v_f);
			cu_pkg::cond_le: taken = z_f | (n_f != v_f);
			cu_pkg::cond_al: taken = 1'b1;
			default:         taken = 1'b0;	// Code 15 is undefined
		endcase
	end

endmodule

// ==== cycle_sequencer.sv ====
`timescale 1ns/1ps

module cycle_sequencer
(
	input  logic                       clock,
	input  logic                       cpucycle_rst,
	input  logic [cu_pkg::word_w-1:0]  pc,
	input  logic [cu_pkg::word_w-1:0]  brkpnt,
	input  logic                       instr_done,	// Last cycle of current instruction
	output logic [cu_pkg::cycle_w-1:0] cycle,
	output logic                       halted		// Sticky breakpoint flag
);

	logic brk_set;	// PC sitting on the breakpoint

	// The hit is only checked at fetch, so an instruction in flight always
	// completes. The fetch word of the hit cycle drives only the MAR and the
	// ALU selects; the PC write is in cyc_pc_wb, which is not reached
	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			cycle   <= cu_pkg::cyc_fetch;
			brk_set <= 1'b0;
		end
		else if (brk_set)
		begin
			if (pc != brkpnt)
				brk_set <= 1'b0;	// Released, count stays at fetch one more clock
		end
		else if ((cycle == cu_pkg::cyc_fetch) && (pc == brkpnt))
			brk_set <= 1'b1;		// Hold at fetch
		else if (instr_done || (cycle == cu_pkg::cyc_exec))
			cycle <= cu_pkg::cyc_fetch;	// Next instruction
		else
			cycle <= cycle + (cu_pkg::cycle_w)'(1);
	end

	assign halted = brk_set;

endmodule

// ==== cex_if.sv ====
`timescale 1ns/1ps

// CEX load from the execute controller and window decision back from the tracker
interface cex_if;

	logic                     cex_load;			// Pulse in execute cycle of CEX
	logic                     cex_cond_true;	// Condition result at load
	logic [2:0]               cex_true_cnt;		// Instructions in the true window
	logic [2:0]               cex_false_cnt;	// Instructions in the false window
	logic                     decode_step;		// High in every decode cycle
	logic                     cex_skip;			// Current instruction ruled out
	logic [cu_pkg::cex_w-1:0] cex_state;

	modport exec
	(
		output cex_load, cex_cond_true, cex_true_cnt, cex_false_cnt, decode_step,
		input  cex_skip
	);

	modport tracker
	(
		input  cex_load, cex_cond_true, cex_true_cnt, cex_false_cnt, decode_step,
		output cex_skip, cex_state
	);

endinterface

// ==== cu_pkg.sv ====
package cu_pkg;

	localparam int word_w     = 16;	// Data and address width
	localparam int bus_ctrl_w = 7;	// {w/b, src[2:0], dst[2:0]}
	localparam int rnum_w     = 5;	// Register number
	localparam int cycle_w    = 4;	// Instruction cycle counter
	localparam int op_w       = 7;	// Decoded opcode
	localparam int cond_w     = 4;	// Condition code field
	localparam int cex_w      = 8;	// {active, result, true cnt, false cnt}
	localparam int alu_op_w   = 6;	// {operation, w/b}

	// Bus source and destination codes
	localparam logic [2:0] bus_mdr = 3'd0;	// MDR as source, MAR/MDR as destination
	localparam logic [2:0] bus_reg = 3'd1;	// Register file
	localparam logic [2:0] bus_ir  = 3'd2;	// Instruction register
	localparam logic [2:0] bus_alu = 3'd3;	// ALU result

	localparam logic [bus_ctrl_w-1:0] bus_ctrl_idle = 7'b1111111;	// No transfer

	localparam logic [1:0] psw_src_alu  = 2'b00;	// PSW flags follow the ALU
	localparam logic [1:0] psw_src_none = 2'b11;	// PSW left alone

	localparam logic [2:0] ctrl_mem_read = 3'b100;	// Memory enabled, read, word

	localparam logic [rnum_w-1:0] reg_pc     = 5'd7;	// Program counter
	localparam logic [rnum_w-1:0] reg_const2 = 5'd10;	// Constant +2

	localparam logic [cycle_w-1:0] cyc_fetch   = 4'd1;	// PC to MAR, PC + 2 in ALU
	localparam logic [cycle_w-1:0] cyc_pc_wb   = 4'd2;	// ALU result back to PC
	localparam logic [cycle_w-1:0] cyc_ir_load = 4'd3;	// MDR to IR
	localparam logic [cycle_w-1:0] cyc_decode  = 4'd4;
	localparam logic [cycle_w-1:0] cyc_exec    = 4'd5;

	localparam logic [op_w-1:0] op_beq   = 7'd1;	// First conditional branch
	localparam logic [op_w-1:0] op_bra   = 7'd8;	// Last branch
	localparam logic [op_w-1:0] op_add   = 7'd9;	// First register ALU op
	localparam logic [op_w-1:0] op_bis   = 7'd20;	// Last of the ADD group
	localparam logic [op_w-1:0] op_mov   = 7'd21;
	localparam logic [op_w-1:0] op_sra   = 7'd23;	// Shift group start
	localparam logic [op_w-1:0] op_rrc   = 7'd24;
	localparam logic [op_w-1:0] op_setcc = 7'd29;
	localparam logic [op_w-1:0] op_clrcc = 7'd30;
	localparam logic [op_w-1:0] op_cex   = 7'd31;

	localparam logic [cond_w-1:0] cond_eq = 4'd0;	// Z set
	localparam logic [cond_w-1:0] cond_ne = 4'd1;	// Z clear
	localparam logic [cond_w-1:0] cond_cs = 4'd2;	// C set
	localparam logic [cond_w-1:0] cond_cc = 4'd3;	// C clear
	localparam logic [cond_w-1:0] cond_mi = 4'd4;	// N set
	localparam logic [cond_w-1:0] cond_pl = 4'd5;	// N clear
	localparam logic [cond_w-1:0] cond_vs = 4'd6;	// V set
	localparam logic [cond_w-1:0] cond_vc = 4'd7;	// V clear
	localparam logic [cond_w-1:0] cond_hi = 4'd8;	// Unsigned higher
	localparam logic [cond_w-1:0] cond_ls = 4'd9;	// Unsigned lower or same
	localparam logic [cond_w-1:0] cond_ge = 4'd10;	// Signed greater or equal
	localparam logic [cond_w-1:0] cond_lt = 4'd11;
	localparam logic [cond_w-1:0] cond_gt = 4'd12;
	localparam logic [cond_w-1:0] cond_le = 4'd13;
	localparam logic [cond_w-1:0] cond_al = 4'd14;	// Always

	localparam int psw_c = 0;	// Carry
	localparam int psw_z = 1;	// Zero
	localparam int psw_n = 2;	// Negative
	localparam int psw_v = 4;	// Overflow, bit 3 is SLP

endpackage
